// File: compile.f
+incdir+src
src/ctrl_pkg.sv
src/ctrl_hazard_unit.sv
src/ctrl_fwd_unit.sv
src/ctrl_fsm.sv
src/core_controller.sv
tb/tb_clk_gen.sv
tb/tb_core_controller.sv

// File: Bender.yml
package:
  name: core_controller

sources:
  - include_dirs:
      - src
    files:
      - src/ctrl_pkg.sv
      - src/ctrl_hazard_unit.sv
      - src/ctrl_fwd_unit.sv
      - src/ctrl_fsm.sv
      - src/core_controller.sv

  - target: test
    files:
      - tb/tb_clk_gen.sv
      - tb/tb_core_controller.sv

// File: tb/tb_core_controller.sv
// core controller testbench with directed and random stimulus on the falling
// edge and concurrent assertions for boot, forwarding, stalls, jumps, exceptions
`timescale 1ns/1ps

module tb_core_controller import ctrl_pkg::*;
();

  localparam int WAIT_LIMIT   = 50;
  localparam int RANDOM_STEPS = 300;

  logic         clk;
  logic         rst_n;

  logic         fetch_enable_i;
  logic         illegal_insn_i;
  logic         eret_insn_i;
  logic         pipe_flush_i;
  logic         instr_valid_i;
  jump_kind_t   jump_in_dec_i;
  jump_kind_t   jump_in_id_i;
  logic         branch_taken_ex_i;
  logic         data_req_ex_i;
  logic         data_misaligned_i;
  logic         mult_multicycle_i;
  wr_src_t      wr_ex_i;
  wr_src_t      wr_wb_i;
  wr_src_t      wr_alu_i;
  logic         id_ready_i;
  logic         ex_valid_i;
  logic         exc_req_i;

  pc_ctrl_t     pc_o;
  exc_ctrl_t    exc_o;
  fwd_sel_vec_t fwd_sel_o;
  logic         instr_req_o;
  logic         ctrl_busy_o;
  logic         is_decoding_o;
  logic         halt_if_o;
  logic         halt_id_o;
  logic         deassert_we_o;
  logic         load_stall_o;
  logic         jr_stall_o;

  // reference values from the controller rules
  fwd_sel_vec_t exp_fwd;
  logic         exp_load_stall;
  logic         exp_jr_stall;
  logic         jump_load;
  logic         jump_blocked;
  logic         flush_start;
  logic         flushing;
  logic         boot_wait;
  logic         ack_seen;

  tb_clk_gen clk_gen_i (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  core_controller dut_i (
    .clk (clk), .rst_n (rst_n),
    .fetch_enable_i (fetch_enable_i), .illegal_insn_i (illegal_insn_i),
    .eret_insn_i (eret_insn_i), .pipe_flush_i (pipe_flush_i),
    .instr_valid_i (instr_valid_i), .jump_in_dec_i (jump_in_dec_i),
    .jump_in_id_i (jump_in_id_i), .branch_taken_ex_i (branch_taken_ex_i),
    .data_req_ex_i (data_req_ex_i), .data_misaligned_i (data_misaligned_i),
    .mult_multicycle_i (mult_multicycle_i),
    .wr_ex_i (wr_ex_i), .wr_wb_i (wr_wb_i), .wr_alu_i (wr_alu_i),
    .id_ready_i (id_ready_i), .ex_valid_i (ex_valid_i), .exc_req_i (exc_req_i),
    .pc_o (pc_o), .exc_o (exc_o), .fwd_sel_o (fwd_sel_o),
    .instr_req_o (instr_req_o), .ctrl_busy_o (ctrl_busy_o),
    .is_decoding_o (is_decoding_o), .halt_if_o (halt_if_o), .halt_id_o (halt_id_o),
    .deassert_we_o (deassert_we_o), .load_stall_o (load_stall_o),
    .jr_stall_o (jr_stall_o)
  );

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  // alu result beats wb and wb beats the register file
  function automatic fwd_sel_t operand_source(input logic wb_hit, input logic alu_hit);
    return alu_hit ? SEL_FW_EX : (wb_hit ? SEL_FW_WB : SEL_REGFILE);
  endfunction

  always_comb
  begin
    exp_fwd.a = operand_source(wr_wb_i.we & wr_wb_i.match.a, wr_alu_i.we & wr_alu_i.match.a);
    exp_fwd.b = operand_source(wr_wb_i.we & wr_wb_i.match.b, wr_alu_i.we & wr_alu_i.match.b);
    exp_fwd.c = operand_source(wr_wb_i.we & wr_wb_i.match.c, wr_alu_i.we & wr_alu_i.match.c);
    if (data_misaligned_i)
    begin
      exp_fwd.a = SEL_FW_EX;
      exp_fwd.b = SEL_REGFILE;
    end
    else if (mult_multicycle_i)
      exp_fwd.c = SEL_FW_EX;

    exp_load_stall = data_req_ex_i & wr_ex_i.we &
                     (wr_ex_i.match.a | wr_ex_i.match.b | wr_ex_i.match.c);
    exp_jr_stall   = (jump_in_dec_i == BRANCH_JALR) &
                     ((wr_ex_i.we & wr_ex_i.match.a) | (wr_wb_i.we & wr_wb_i.match.a) |
                      (wr_alu_i.we & wr_alu_i.match.a));
  end

  assign jump_load   = pc_o.set && (pc_o.mux == PC_JUMP || pc_o.mux == PC_ERET);
  assign flush_start = is_decoding_o && pipe_flush_i && !fetch_enable_i;

  // core sits in its reset state until fetch enable is sampled
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      boot_wait <= 1'b1;
    else if (fetch_enable_i)
      boot_wait <= 1'b0;
  end

  // jump or eret load with id stalled blocks loads until id accepts
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      jump_blocked <= 1'b0;
    else if (id_ready_i)
      jump_blocked <= 1'b0;
    else if (jump_load)
      jump_blocked <= 1'b1;
  end

  // pipe flush towards sleep lasts until the core is idle
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      flushing <= 1'b0;
    else if (flush_start)
      flushing <= 1'b1;
    else if (!ctrl_busy_o)
      flushing <= 1'b0;
  end

  // ack as seen by the controller at the last rising edge
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      ack_seen <= 1'b0;
    else
      ack_seen <= exc_o.ack;
  end

  ////////////////////////////////////////
  // failure reporting
  ////////////////////////////////////////

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic value_error(input string test, input logic [7:0] exp, input logic [7:0] act);
    fail_run($sformatf("ERR %s expected %0h actual %0h", test, exp, act));
  endtask

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  reset_outputs : assert property (@(posedge clk) !rst_n |->
    (!instr_req_o && !ctrl_busy_o && !pc_o.set && exc_o == '0 &&
     !halt_if_o && !halt_id_o && deassert_we_o))
    else fail_run("outputs not idle during reset");

  boot_idle : assert property (@(posedge clk) disable iff (!rst_n)
    boot_wait |-> (!instr_req_o && !ctrl_busy_o))
    else value_error("boot_idle", 8'h0,
                     {6'h0, $sampled(instr_req_o), $sampled(ctrl_busy_o)});

  boot_load : assert property (@(posedge clk) disable iff (!rst_n)
    (boot_wait && fetch_enable_i) |=> (pc_o.set && pc_o.mux == PC_BOOT))
    else value_error("boot", {4'h0, 1'b1, PC_BOOT}, $sampled(pc_o));

  fwd_select : assert property (@(posedge clk) disable iff (!rst_n)
    fwd_sel_o == exp_fwd)
    else value_error("forwarding", $sampled(exp_fwd), $sampled(fwd_sel_o));

  load_stall : assert property (@(posedge clk) disable iff (!rst_n)
    load_stall_o == exp_load_stall)
    else value_error("load_stall", $sampled(exp_load_stall), $sampled(load_stall_o));

  jr_stall : assert property (@(posedge clk) disable iff (!rst_n)
    jr_stall_o == exp_jr_stall)
    else value_error("jr_stall", $sampled(exp_jr_stall), $sampled(jr_stall_o));

  stall_kills_we : assert property (@(posedge clk) disable iff (!rst_n)
    (load_stall_o || jr_stall_o) |-> deassert_we_o)
    else value_error("deassert_we", 8'h1, $sampled(deassert_we_o));

  no_jump_in_jr_stall : assert property (@(posedge clk) disable iff (!rst_n)
    jr_stall_o |-> !(pc_o.set && pc_o.mux == PC_JUMP))
    else fail_run("jump load while the jump register stall is raised");

  jump_once : assert property (@(posedge clk) disable iff (!rst_n)
    jump_blocked |-> !jump_load)
    else fail_run("second jump load before id accepted the first");

  branch_taken : assert property (@(posedge clk) disable iff (!rst_n)
    branch_taken_ex_i |->
      (!is_decoding_o && (!pc_o.set || pc_o.mux == PC_BRANCH) && !exc_o.ack))
    else fail_run("taken branch cycle with decode, wrong pc source or exception ack");

  exception_entry : assert property (@(posedge clk) disable iff (!rst_n)
    (is_decoding_o && exc_req_i && !eret_insn_i &&
     (jump_in_dec_i == BRANCH_NONE || jump_in_dec_i == BRANCH_COND)) |->
      (exc_o.ack && exc_o.save_id && halt_id_o && pc_o.set && pc_o.mux == PC_EXCEPTION))
    else value_error("exception", {4'h0, 4'b1010}, {4'h0, $sampled(exc_o)});

  // source drops the request right after the acknowledged cycle
  single_ack : assert property (@(posedge clk) disable iff (!rst_n)
    exc_o.ack |=> !exc_o.ack)
    else fail_run("exception acknowledge held for more than one cycle");

  flush_halts : assert property (@(posedge clk) disable iff (!rst_n)
    (flush_start || flushing) |-> (halt_if_o && halt_id_o))
    else value_error("flush_halt", 8'h3, {6'h0, $sampled(halt_if_o), $sampled(halt_id_o)});

  // sleep is idle with the halts set
  wake_on_exc : assert property (@(posedge clk) disable iff (!rst_n)
    (!ctrl_busy_o && halt_if_o && exc_req_i) |=> ctrl_busy_o)
    else value_error("wake", 8'h1, $sampled(ctrl_busy_o));

  ////////////////////////////////////////
  // wait helpers
  ////////////////////////////////////////

  task automatic wait_reset_release();
    int n;
    n = 0;
    while (!rst_n && n < WAIT_LIMIT)
    begin
      @(negedge clk);
      n++;
    end
    if (!rst_n)
      fail_run("reset never released");
  endtask

  task automatic wait_decoding();
    int n;
    n = 0;
    while (!is_decoding_o && n < WAIT_LIMIT)
    begin
      @(negedge clk);
      n++;
    end
    if (!is_decoding_o)
      fail_run("controller never reached decode");
  endtask

  // request drops on the falling edge after the rising edge that took the ack
  task automatic wait_exc_ack();
    int n;
    n = 0;
    while (!ack_seen && n < WAIT_LIMIT)
    begin
      @(negedge clk);
      n++;
    end
    if (!ack_seen)
      fail_run("exception request never acknowledged");
    else
      exc_req_i = 1'b0;
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while ((ctrl_busy_o || instr_req_o) && n < WAIT_LIMIT)
    begin
      @(negedge clk);
      n++;
    end
    if (ctrl_busy_o || instr_req_o)
      fail_run("controller did not go to sleep after the pipe flush");
  endtask

  task automatic wait_busy();
    int n;
    n = 0;
    while (!ctrl_busy_o && n < WAIT_LIMIT)
    begin
      @(negedge clk);
      n++;
    end
    if (!ctrl_busy_o)
      fail_run("controller did not wake up on the exception request");
  endtask

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  initial
  begin
    int      r;
    int unsigned seed_dummy;

    seed_dummy = $urandom(32'ha8f4);
    fetch_enable_i    = 1'b0;
    illegal_insn_i    = 1'b0;
    eret_insn_i       = 1'b0;
    pipe_flush_i      = 1'b0;
    instr_valid_i     = 1'b0;
    jump_in_dec_i     = BRANCH_NONE;
    // every taken branch comes from a conditional branch in id
    jump_in_id_i      = BRANCH_COND;
    branch_taken_ex_i = 1'b0;
    data_req_ex_i     = 1'b0;
    data_misaligned_i = 1'b0;
    mult_multicycle_i = 1'b0;
    wr_ex_i           = '0;
    wr_wb_i           = '0;
    wr_alu_i          = '0;
    id_ready_i        = 1'b1;
    ex_valid_i        = 1'b0;
    exc_req_i         = 1'b0;

    wait_reset_release();

    // boot
    repeat (2) @(negedge clk);
    fetch_enable_i = 1'b1;
    instr_valid_i  = 1'b1;
    wait_decoding();

    // random hazards, forwarding, jumps and branches inside decode
    for (int i = 0; i < RANDOM_STEPS; i++)
    begin
      @(negedge clk);
      wr_ex_i           = wr_src_t'($urandom_range(0, 15));
      wr_wb_i           = wr_src_t'($urandom_range(0, 15));
      wr_alu_i          = wr_src_t'($urandom_range(0, 15));
      data_req_ex_i     = $urandom_range(0, 1);
      data_misaligned_i = ($urandom_range(0, 3) == 0);
      mult_multicycle_i = ($urandom_range(0, 3) == 0);
      illegal_insn_i    = ($urandom_range(0, 7) == 0);
      jump_in_dec_i     = jump_kind_t'($urandom_range(0, 3));
      id_ready_i        = ($urandom_range(0, 2) != 0);
      instr_valid_i     = ($urandom_range(0, 7) != 0);
      r                 = $urandom_range(0, 3);
      branch_taken_ex_i = (r == 0) && !branch_taken_ex_i;
    end

    // jump while id is stalled
    @(negedge clk);
    wr_ex_i           = '0;
    wr_wb_i           = '0;
    wr_alu_i          = '0;
    data_req_ex_i     = 1'b0;
    data_misaligned_i = 1'b0;
    mult_multicycle_i = 1'b0;
    illegal_insn_i    = 1'b0;
    branch_taken_ex_i = 1'b0;
    instr_valid_i     = 1'b1;
    jump_in_dec_i     = BRANCH_NONE;
    id_ready_i        = 1'b1;
    @(negedge clk);
    jump_in_dec_i = BRANCH_JAL;
    id_ready_i    = 1'b0;
    repeat (4) @(negedge clk);
    id_ready_i = 1'b1;
    @(negedge clk);
    jump_in_dec_i = BRANCH_NONE;

    // exception held off by a taken branch, then taken in decode
    @(negedge clk);
    exc_req_i         = 1'b1;
    branch_taken_ex_i = 1'b1;
    @(negedge clk);
    branch_taken_ex_i = 1'b0;
    wait_exc_ack();

    // pipe flush with fetch disabled, then sleep
    @(negedge clk);
    fetch_enable_i = 1'b0;
    pipe_flush_i   = 1'b1;
    @(negedge clk);
    pipe_flush_i = 1'b0;
    repeat (3) @(negedge clk);
    ex_valid_i = 1'b1;
    wait_idle();
    ex_valid_i = 1'b0;

    // exception wakes the core up
    repeat (2) @(negedge clk);
    exc_req_i = 1'b1;
    wait_busy();
    wait_exc_ack();
    repeat (4) @(negedge clk);

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// File: tb/tb_clk_gen.sv
// testbench clock and reset source
// 40 ns clock, reset held low for a number of cycles
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 10
)
(
  output logic clk_o,
  output logic rst_n_o
);

  initial
  begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // release on a falling edge, away from the sampling edge
  initial
  begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

// File: src/core_controller.sv
// core controller top: hazard unit, forwarding unit and main fsm
`timescale 1ns/1ps

module core_controller import ctrl_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,

  input  logic         fetch_enable_i,
  // decoder
  input  logic         illegal_insn_i,
  input  logic         eret_insn_i,
  input  logic         pipe_flush_i,
  input  logic         instr_valid_i,
  input  jump_kind_t   jump_in_dec_i,
  input  jump_kind_t   jump_in_id_i,
  input  logic         branch_taken_ex_i,
  // lsu and multiplier
  input  logic         data_req_ex_i,
  input  logic         data_misaligned_i,
  input  logic         mult_multicycle_i,
  // writing stages
  input  wr_src_t      wr_ex_i,
  input  wr_src_t      wr_wb_i,
  input  wr_src_t      wr_alu_i,
  input  logic         id_ready_i,
  input  logic         ex_valid_i,
  input  logic         exc_req_i,

  output pc_ctrl_t     pc_o,
  output exc_ctrl_t    exc_o,
  output fwd_sel_vec_t fwd_sel_o,
  output logic         instr_req_o,
  output logic         ctrl_busy_o,
  output logic         is_decoding_o,
  output logic         halt_if_o,
  output logic         halt_id_o,
  output logic         deassert_we_o,
  output logic         load_stall_o,
  output logic         jr_stall_o
);

  logic is_decoding;
  logic jr_stall;

  ctrl_hazard_unit hazard_i (
    .is_decoding_i  (is_decoding),
    .illegal_insn_i (illegal_insn_i),
    .data_req_ex_i  (data_req_ex_i),
    .jump_in_dec_i  (jump_in_dec_i),
    .wr_ex_i        (wr_ex_i),
    .wr_wb_i        (wr_wb_i),
    .wr_alu_i       (wr_alu_i),
    .load_stall_o   (load_stall_o),
    .jr_stall_o     (jr_stall),
    .deassert_we_o  (deassert_we_o)
  );

  ctrl_fwd_unit fwd_i (
    .wr_wb_i           (wr_wb_i),
    .wr_alu_i          (wr_alu_i),
    .data_misaligned_i (data_misaligned_i),
    .mult_multicycle_i (mult_multicycle_i),
    .fwd_sel_o         (fwd_sel_o)
  );

  ctrl_fsm fsm_i (
    .clk (clk), .rst_n (rst_n),
    .fetch_enable_i (fetch_enable_i), .instr_valid_i (instr_valid_i),
    .branch_taken_ex_i (branch_taken_ex_i), .eret_insn_i (eret_insn_i),
    .pipe_flush_i (pipe_flush_i), .exc_req_i (exc_req_i),
    .id_ready_i (id_ready_i), .ex_valid_i (ex_valid_i),
    .jr_stall_i (jr_stall), .jump_in_dec_i (jump_in_dec_i),
    .pc_o (pc_o), .exc_o (exc_o),
    .instr_req_o (instr_req_o), .ctrl_busy_o (ctrl_busy_o),
    .is_decoding_o (is_decoding), .halt_if_o (halt_if_o), .halt_id_o (halt_id_o)
  );

  assign is_decoding_o = is_decoding;
  assign jr_stall_o    = jr_stall;

  // taken branch in ex was a conditional branch in id one cycle earlier
  a_branch_from_id : assert property (@(posedge clk) disable iff (!rst_n)
    branch_taken_ex_i |-> $past(jump_in_id_i == BRANCH_COND))
    else $error("taken branch without conditional branch in id");

endmodule

// File: src/ctrl_fsm.sv
// main control fsm for boot, sleep, decode, jumps, branches, exceptions,
// eret and pipeline flush, plus the jump-done register
`timescale 1ns/1ps

module ctrl_fsm import ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,

  input  logic       fetch_enable_i,
  input  logic       instr_valid_i,
  input  logic       branch_taken_ex_i,
  input  logic       eret_insn_i,
  input  logic       pipe_flush_i,
  input  logic       exc_req_i,
  input  logic       id_ready_i,
  input  logic       ex_valid_i,
  input  logic       jr_stall_i,
  input  jump_kind_t jump_in_dec_i,

  output pc_ctrl_t   pc_o,
  output exc_ctrl_t  exc_o,

  output logic       instr_req_o,
  output logic       ctrl_busy_o,
  output logic       is_decoding_o,
  output logic       halt_if_o,
  output logic       halt_id_o
);

  ctrl_state_t state_q;
  ctrl_state_t state_d;

  // set once a jump or eret has loaded the pc
  // blocks a repeated load while id is stalled
  logic jump_done_q;
  logic jump_done_d;

  ////////////////////////////////////////
  // next state and outputs
  ////////////////////////////////////////

  always_comb
  begin
    instr_req_o   = 1'b1;
    ctrl_busy_o   = 1'b1;
    is_decoding_o = 1'b0;
    halt_if_o     = 1'b0;
    halt_id_o     = 1'b0;

    pc_o.set      = 1'b0;
    pc_o.mux      = PC_BOOT;
    exc_o         = '0;

    jump_done_d   = jump_done_q;
    state_d       = state_q;

    unique case (state_q)
      // idle out of reset until fetch is enabled
      RESET:
      begin
        instr_req_o = 1'b0;
        ctrl_busy_o = 1'b0;
        if (fetch_enable_i)
          state_d = BOOT_SET;
      end

      // load the boot address into the fetch stage
      BOOT_SET:
      begin
        pc_o.set = 1'b1;
        pc_o.mux = PC_BOOT;
        state_d  = FIRST_FETCH;
      end

      // empty pipeline waits for fetch enable or an exception
      SLEEP:
      begin
        instr_req_o = 1'b0;
        ctrl_busy_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        if (fetch_enable_i || exc_req_i)
          state_d = FIRST_FETCH;
      end

      FIRST_FETCH:
      begin
        // wait for the first instruction to reach id
        if (id_ready_i)
          state_d = DECODE;

        // exception on wake-up
        // id is empty so the if pc is saved
        if (exc_req_i)
        begin
          pc_o.set      = 1'b1;
          pc_o.mux      = PC_EXCEPTION;
          exc_o.ack     = 1'b1;
          exc_o.save_if = 1'b1;
        end
      end

      DECODE:
      begin
        // a taken branch in ex kills the instruction in id
        if (instr_valid_i && !branch_taken_ex_i)
        begin
          is_decoding_o = 1'b1;

          if (jump_in_dec_i == BRANCH_JAL || jump_in_dec_i == BRANCH_JALR)
          begin
            // target is known in id so the jump goes out right away
            pc_o.mux = PC_JUMP;
            // jalr waits for its operand
            if (!jr_stall_i && !jump_done_q)
            begin
              pc_o.set    = 1'b1;
              jump_done_d = 1'b1;
            end
          end
          else if (eret_insn_i)
          begin
            pc_o.mux         = PC_ERET;
            exc_o.restore_id = 1'b1;
            if (!jump_done_q)
            begin
              pc_o.set    = 1'b1;
              jump_done_d = 1'b1;
            end
          end
          else if (exc_req_i)
          begin
            pc_o.set      = 1'b1;
            pc_o.mux      = PC_EXCEPTION;
            exc_o.ack     = 1'b1;
            exc_o.save_id = 1'b1;
            // instruction in id must not reach ex
            halt_id_o     = 1'b1;
          end

          // wfi or eret back into sleep
          if (pipe_flush_i || (eret_insn_i && !fetch_enable_i))
          begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = FLUSH_EX;
          end
        end

        // conditional branch resolved taken in ex
        if (branch_taken_ex_i)
        begin
          pc_o.set = 1'b1;
          pc_o.mux = PC_BRANCH;
        end
      end

      // drain ex with a nop behind it
      FLUSH_EX:
      begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (ex_valid_i)
          state_d = FLUSH_WB;
      end

      // wb drains this cycle
      FLUSH_WB:
      begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (fetch_enable_i)
        begin
          halt_if_o = 1'b0;
          state_d   = DECODE;
        end
        else
        begin
          state_d = SLEEP;
        end
      end

      default:
      begin
        instr_req_o = 1'b0;
        ctrl_busy_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  ////////////////////////////////////////
  // state registers
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q     <= RESET;
      jump_done_q <= 1'b0;
    end
    else
    begin
      state_q     <= state_d;
      // id accepting a new instruction releases the block
      jump_done_q <= jump_done_d & ~id_ready_i;
    end
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  // without branch prediction the branch shadow is always flushed
  a_no_b2b_branch : assert property (@(posedge clk) disable iff (!rst_n)
    branch_taken_ex_i |=> !branch_taken_ex_i)
    else $error("two taken branches back to back");

endmodule

// File: src/ctrl_fwd_unit.sv
// operand forwarding select for a, b and c with the misaligned access and
// multi-cycle multiply overrides
`timescale 1ns/1ps

module ctrl_fwd_unit import ctrl_pkg::*;
(
  input  wr_src_t      wr_wb_i,
  input  wr_src_t      wr_alu_i,
  input  logic         data_misaligned_i,
  input  logic         mult_multicycle_i,
  output fwd_sel_vec_t fwd_sel_o
);

  // source of one operand
  // ex result is younger than wb so it wins
  function automatic fwd_sel_t pick_src(input logic wb_hit, input logic alu_hit);
    fwd_sel_t sel;
    sel = SEL_REGFILE;
    if (wb_hit)
      sel = SEL_FW_WB;
    if (alu_hit)
      sel = SEL_FW_EX;
    return sel;
  endfunction

  logic wb_on;
  logic alu_on;

  // stage enables gate the per-operand matches
  assign wb_on  = wr_wb_i.we;
  assign alu_on = wr_alu_i.we;

  ////////////////////////////////////////
  // select logic
  ////////////////////////////////////////

  always_comb
  begin
    fwd_sel_o.a = pick_src(wb_on && wr_wb_i.match.a, alu_on && wr_alu_i.match.a);
    fwd_sel_o.b = pick_src(wb_on && wr_wb_i.match.b, alu_on && wr_alu_i.match.b);
    fwd_sel_o.c = pick_src(wb_on && wr_wb_i.match.c, alu_on && wr_alu_i.match.c);

    // second half of a misaligned access
    // a takes the address from ex, b reads the regfile again
    if (data_misaligned_i)
    begin
      fwd_sel_o.a = SEL_FW_EX;
      fwd_sel_o.b = SEL_REGFILE;
    end
    else if (mult_multicycle_i)
    begin
      // multiplier keeps its partial result on operand c
      fwd_sel_o.c = SEL_FW_EX;
    end
  end

endmodule

// File: src/ctrl_hazard_unit.sv
// hazard unit with load-use stall, jump-register stall and write enable
// suppression for the instruction in id
`timescale 1ns/1ps

module ctrl_hazard_unit import ctrl_pkg::*;
(
  input  logic       is_decoding_i,
  input  logic       illegal_insn_i,
  input  logic       data_req_ex_i,
  input  jump_kind_t jump_in_dec_i,
  input  wr_src_t    wr_ex_i,
  input  wr_src_t    wr_wb_i,
  input  wr_src_t    wr_alu_i,
  output logic       load_stall_o,
  output logic       jr_stall_o,
  output logic       deassert_we_o
);

  logic load_hit;
  logic jr_hit;

  ////////////////////////////////////////
  // stall detection
  ////////////////////////////////////////

  always_comb
  begin
    // load in ex whose result is needed by any operand in id
    load_hit = data_req_ex_i && wr_ex_i.we && (|wr_ex_i.match);

    // jalr target comes from operand a
    // stall whenever any stage still has to write it back
    jr_hit = 1'b0;
    if (jump_in_dec_i == BRANCH_JALR)
    begin
      jr_hit = (wr_wb_i.we  && wr_wb_i.match.a)  ||
               (wr_ex_i.we  && wr_ex_i.match.a)  ||
               (wr_alu_i.we && wr_alu_i.match.a);
    end
  end

  assign load_stall_o = load_hit;
  assign jr_stall_o   = jr_hit;

  // no register write for the instruction in id when
  // - it is stalled
  // - it is illegal
  // - the fsm is not decoding
  // fsm state is irrelevant for the jr stall since we is killed anyway
  // outside decode
  assign deassert_we_o = load_hit | jr_hit | illegal_insn_i | ~is_decoding_i;

endmodule

// File: src/ctrl_pkg.sv
// controller types: raw width vectors, enums for pc source, forwarding,
// jump kind and fsm state, and the packed structs passed between blocks
package ctrl_pkg;

  `include "ctrl_cfg.svh"

  // plain vectors for the meaningful widths
  typedef logic [`CTRL_PC_MUX_W-1:0]  pc_mux_raw_t;
  typedef logic [`CTRL_FWD_SEL_W-1:0] fwd_sel_raw_t;
  typedef logic [`CTRL_JUMP_W-1:0]    jump_raw_t;
  typedef logic [`CTRL_STATE_W-1:0]   state_raw_t;

  // pc source, encoding kept compatible with the fetch stage mux
  typedef enum pc_mux_raw_t {
    PC_BOOT      = 3'b000,
    PC_JUMP      = 3'b010,
    PC_BRANCH    = 3'b011,
    PC_EXCEPTION = 3'b100,
    PC_ERET      = 3'b101
  } pc_mux_t;

  typedef enum fwd_sel_raw_t {
    SEL_REGFILE = 2'b00,
    SEL_FW_EX   = 2'b01,
    SEL_FW_WB   = 2'b10
  } fwd_sel_t;

  typedef enum jump_raw_t {
    BRANCH_NONE = 2'b00,
    BRANCH_JAL  = 2'b01,
    BRANCH_JALR = 2'b10,
    BRANCH_COND = 2'b11
  } jump_kind_t;

  typedef enum state_raw_t {
    RESET, BOOT_SET, SLEEP, FIRST_FETCH, DECODE, FLUSH_EX, FLUSH_WB
  } ctrl_state_t;

  // destination of a stage equals source reg of operand a, b or c in id
  typedef struct packed { logic a; logic b; logic c; } reg_match_t;

  // one writing stage: enable plus per-operand match
  typedef struct packed { logic we; reg_match_t match; } wr_src_t;

  typedef struct packed { fwd_sel_t a; fwd_sel_t b; fwd_sel_t c; } fwd_sel_vec_t;

  // new pc request and its source
  typedef struct packed { logic set; pc_mux_t mux; } pc_ctrl_t;

  typedef struct packed {
    logic ack;
    logic save_if;
    logic save_id;
    logic restore_id;
  } exc_ctrl_t;

endpackage

// File: src/ctrl_cfg.svh
// bit widths shared by the core controller: pc source, forwarding select,
// jump kind and fsm state encoding
`ifndef CTRL_CFG_SVH
`define CTRL_CFG_SVH

// pc source select towards the fetch stage
// boot, jump, branch, exception and eret need 3 bits
`define CTRL_PC_MUX_W 3

// operand forwarding select
// register file, ex result or wb result
`define CTRL_FWD_SEL_W 2

// jump kind coming from the decoder
// none, jal, jalr or conditional branch
`define CTRL_JUMP_W 2

// main fsm state encoding
// seven states fit into 3 bits
`define CTRL_STATE_W 3

`endif
